// File: design/cart_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, hotspot map, scheme encoding and bus structs for the
// cartridge bank-switching mapper. Referenced by scoped name only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package cart_pkg;

	// Bus and bank widths
	localparam int CPU_ADDR_W = 13;
	localparam int ROM_ADDR_W = 19;
	localparam int RAM_ADDR_W = 11;
	localparam int BANK_W     = 3;

	// Switchable E0 slices, the fourth slice is fixed
	localparam logic [1:0] SLICE_COUNT = 2'd3;

	// First hotspot of each standard scheme
	localparam logic [CPU_ADDR_W-1:0] HOT_F8_FIRST = 13'h1FF8;
	localparam logic [CPU_ADDR_W-1:0] HOT_F6_FIRST = 13'h1FF6;
	localparam logic [CPU_ADDR_W-1:0] HOT_F4_FIRST = 13'h1FF4;

	// Bank counts, one bit wider than a bank number so 8 fits
	localparam logic [BANK_W:0] F8_BANKS = 4'd2;
	localparam logic [BANK_W:0] F6_BANKS = 4'd4;
	localparam logic [BANK_W:0] F4_BANKS = 4'd8;

	localparam logic [BANK_W-1:0] F8_RESET_BANK = 3'd1;

	// E0 hotspots, slot in bits 4:3 and bank in bits 2:0
	localparam logic [CPU_ADDR_W-1:0] E0_HOT_FIRST = 13'h1FE0;
	localparam logic [CPU_ADDR_W-1:0] E0_HOT_LAST  = 13'h1FF7;
	localparam logic [BANK_W-1:0]     E0_FIXED_BANK = 3'd7;

	// Superchip ports, 128 bytes each
	localparam logic [CPU_ADDR_W-1:0] SC_WRITE_BASE = 13'h1000;
	localparam logic [CPU_ADDR_W-1:0] SC_READ_BASE  = 13'h1080;
	localparam int                    SC_PORT_W     = 7;

	// Bank-write slot 0 is the main bank, slots 1 to 3 are E0 slices 0 to 2
	localparam logic [1:0] SLOT_MAIN = 2'd0;

	typedef enum logic [2:0] {
		SCHEME_4K = 3'd0,
		SCHEME_F8 = 3'd1,
		SCHEME_F6 = 3'd2,
		SCHEME_F4 = 3'd3,
		SCHEME_E0 = 3'd4
	} mapper_scheme_e;

	typedef struct packed {
		logic              valid;
		logic [1:0]        slot;
		logic [BANK_W-1:0] bank;
	} bank_write_t;

	typedef struct packed {
		logic [BANK_W-1:0] main_bank;
		logic [BANK_W-1:0] slice0;
		logic [BANK_W-1:0] slice1;
		logic [BANK_W-1:0] slice2;
	} bank_state_t;

	typedef struct packed {
		logic                  sel;
		logic                  rw;     // 1 is a read
		logic [RAM_ADDR_W-1:0] addr;
	} ram_port_t;

endpackage

`default_nettype wire

// File: design/hotspot_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational hotspot decoder. Turns a bus access marked by a_change
// into a one-cycle bank-write request for the selected scheme.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module hotspot_decoder (
	input  wire logic [cart_pkg::CPU_ADDR_W-1:0] a_in,
	input  wire logic                            a_change,
	input  wire cart_pkg::mapper_scheme_e        scheme,
	output cart_pkg::bank_write_t                bank_write
);

	logic [cart_pkg::CPU_ADDR_W-1:0] hot_first;
	logic [cart_pkg::BANK_W:0]       hot_count;
	logic                            std_scheme;
	logic [cart_pkg::CPU_ADDR_W-1:0] offset;
	logic                            std_hit;
	logic                            e0_hit;

	// Hotspot window of the standard schemes
	always_comb begin
		hot_first  = cart_pkg::HOT_F8_FIRST;
		hot_count  = cart_pkg::F8_BANKS;
		std_scheme = 1'b0;
		case (scheme)
			cart_pkg::SCHEME_F8: begin
				hot_first  = cart_pkg::HOT_F8_FIRST;
				hot_count  = cart_pkg::F8_BANKS;
				std_scheme = 1'b1;
			end
			cart_pkg::SCHEME_F6: begin
				hot_first  = cart_pkg::HOT_F6_FIRST;
				hot_count  = cart_pkg::F6_BANKS;
				std_scheme = 1'b1;
			end
			cart_pkg::SCHEME_F4: begin
				hot_first  = cart_pkg::HOT_F4_FIRST;
				hot_count  = cart_pkg::F4_BANKS;
				std_scheme = 1'b1;
			end
			default: begin
				std_scheme = 1'b0;
			end
		endcase
	end

	// Offset from the first hotspot is the bank number
	assign offset = a_in - hot_first;

	assign std_hit = std_scheme && (a_in >= hot_first)
		&& (offset[cart_pkg::CPU_ADDR_W-1:cart_pkg::BANK_W+1] == '0)
		&& (offset[cart_pkg::BANK_W:0] < hot_count);

	assign e0_hit = (scheme == cart_pkg::SCHEME_E0)
		&& (a_in >= cart_pkg::E0_HOT_FIRST) && (a_in <= cart_pkg::E0_HOT_LAST)
		&& (a_in[4:3] < cart_pkg::SLICE_COUNT);

	always_comb begin
		bank_write = '0;
		if (a_change) begin
			if (std_hit) begin
				bank_write.valid = 1'b1;
				bank_write.slot  = cart_pkg::SLOT_MAIN;
				bank_write.bank  = offset[cart_pkg::BANK_W-1:0];
			end else if (e0_hit) begin
				bank_write.valid = 1'b1;
				// Slices sit one above the main bank slot
				bank_write.slot  = a_in[4:3] + 2'd1;
				bank_write.bank  = a_in[2:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/bank_registers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank register file. Holds the main bank and the three E0 slices and
// applies decoder requests on the next rising edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module bank_registers (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire cart_pkg::mapper_scheme_e scheme,
	input  wire cart_pkg::bank_write_t    bank_write,
	output cart_pkg::bank_state_t         bank_state
);

	cart_pkg::bank_state_t banks;
	logic [cart_pkg::BANK_W-1:0] reset_bank;

	// F8 powers up in its upper bank
	assign reset_bank = (scheme == cart_pkg::SCHEME_F8) ?
		cart_pkg::F8_RESET_BANK : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			banks.main_bank <= reset_bank;
			banks.slice0    <= '0;
			banks.slice1    <= '0;
			banks.slice2    <= '0;
		end else if (bank_write.valid) begin
			case (bank_write.slot)
				cart_pkg::SLOT_MAIN: begin
					banks.main_bank <= bank_write.bank;
				end
				2'd1: begin
					banks.slice0 <= bank_write.bank;
				end
				2'd2: begin
					banks.slice1 <= bank_write.bank;
				end
				default: begin
					banks.slice2 <= bank_write.bank;
				end
			endcase
		end
	end

	assign bank_state = banks;

endmodule

`default_nettype wire

// File: design/address_composer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational address composer. Builds the ROM address from the bus
// address and bank state, decodes the Superchip RAM ports and data_oe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module address_composer (
	input  wire logic [cart_pkg::CPU_ADDR_W-1:0] a_in,
	input  wire logic                            sc,
	input  wire cart_pkg::mapper_scheme_e        scheme,
	input  wire cart_pkg::bank_state_t           bank_state,
	output logic [cart_pkg::ROM_ADDR_W-1:0]      rom_a,
	output cart_pkg::ram_port_t                  ram,
	output logic                                 data_oe
);

	localparam int STD_PAD = cart_pkg::ROM_ADDR_W - cart_pkg::BANK_W - 12;
	localparam int E0_PAD  = cart_pkg::ROM_ADDR_W - cart_pkg::BANK_W - 10;
	localparam int RAM_PAD = cart_pkg::RAM_ADDR_W - cart_pkg::SC_PORT_W;

	logic [cart_pkg::BANK_W-1:0] std_bank;
	logic [cart_pkg::BANK_W-1:0] e0_bank;
	logic                        in_wr_port;
	logic                        in_rd_port;
	logic                        ram_sel;

	// Plain 4K sits in bank 0
	assign std_bank = (scheme == cart_pkg::SCHEME_4K) ? '0 : bank_state.main_bank;

	// 1K slice chosen by bits 11:10
	always_comb begin
		case (a_in[11:10])
			2'd0:    e0_bank = bank_state.slice0;
			2'd1:    e0_bank = bank_state.slice1;
			2'd2:    e0_bank = bank_state.slice2;
			default: e0_bank = cart_pkg::E0_FIXED_BANK;
		endcase
	end

	always_comb begin
		if (scheme == cart_pkg::SCHEME_E0) begin
			rom_a = {{E0_PAD{1'b0}}, e0_bank, a_in[9:0]};
		end else begin
			rom_a = {{STD_PAD{1'b0}}, std_bank, a_in[11:0]};
		end
	end

	// Superchip ports occupy the first 256 bytes of the window
	assign in_wr_port = a_in[cart_pkg::CPU_ADDR_W-1:cart_pkg::SC_PORT_W]
		== cart_pkg::SC_WRITE_BASE[cart_pkg::CPU_ADDR_W-1:cart_pkg::SC_PORT_W];
	assign in_rd_port = a_in[cart_pkg::CPU_ADDR_W-1:cart_pkg::SC_PORT_W]
		== cart_pkg::SC_READ_BASE[cart_pkg::CPU_ADDR_W-1:cart_pkg::SC_PORT_W];

	assign ram_sel = sc && (in_wr_port || in_rd_port);

	always_comb begin
		ram.sel  = ram_sel;
		ram.rw   = !(ram_sel && in_wr_port);
		ram.addr = ram_sel ? {{RAM_PAD{1'b0}}, a_in[cart_pkg::SC_PORT_W-1:0]} : '0;
	end

	// Release the data bus while the RAM is being written
	assign data_oe = a_in[12] && !(ram.sel && !ram.rw);

endmodule

`default_nettype wire

// File: design/cart_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cartridge mapper top level. The decoder feeds the bank registers,
// which feed the address composer. Scheme changes only under reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module cart_mapper (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire cart_pkg::mapper_scheme_e        scheme,
	input  wire logic                            sc,
	input  wire logic [cart_pkg::CPU_ADDR_W-1:0] a_in,
	input  wire logic                            a_change,
	output logic [cart_pkg::ROM_ADDR_W-1:0]      rom_a,
	output cart_pkg::ram_port_t                  ram,
	output logic                                 data_oe
);

	cart_pkg::bank_write_t bank_write;
	cart_pkg::bank_state_t bank_state;

	hotspot_decoder i_hotspot_decoder (
		.a_in       (a_in),
		.a_change   (a_change),
		.scheme     (scheme),
		.bank_write (bank_write)
	);

	bank_registers i_bank_registers (
		.clk        (clk),
		.reset      (reset),
		.scheme     (scheme),
		.bank_write (bank_write),
		.bank_state (bank_state)
	);

	address_composer i_address_composer (
		.a_in       (a_in),
		.sc         (sc),
		.scheme     (scheme),
		.bank_state (bank_state),
		.rom_a      (rom_a),
		.ram        (ram),
		.data_oe    (data_oe)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source. 20 ns clock, reset high for three
// rising edges at start and again after each reset_req pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	input  wire logic reset_req,
	output logic      clk,
	output logic      reset
);

	localparam int HALF_PERIOD_NS = 10;
	localparam int RESET_CYCLES   = 3;
	localparam int DRIVE_DELAY_NS = 2;

	int   reset_left;
	logic req_seen;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// The first edge already sees reset high from time zero
	initial begin
		reset      = 1'b1;
		reset_left = RESET_CYCLES - 1;
	end

	always @(posedge clk) begin
		req_seen = reset_req;
		#(DRIVE_DELAY_NS);
		if (req_seen) begin
			reset_left = RESET_CYCLES;
		end
		reset = (reset_left > 0);
		if (reset_left > 0) begin
			reset_left = reset_left - 1;
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_cart_checks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected-output function and typed compare tasks for the mapper
// testbench. Included inside the testbench top module.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_CART_CHECKS_SVH
`define TB_CART_CHECKS_SVH

typedef struct packed {
	logic [cart_pkg::ROM_ADDR_W-1:0] rom_a;
	cart_pkg::ram_port_t             ram;
	logic                            oe;
} expected_t;

// Outputs predicted from scheme, Superchip enable, bus address and model banks
function automatic expected_t expected_outputs(
	input cart_pkg::mapper_scheme_e        scheme_sel,
	input logic                            sc_en,
	input logic [cart_pkg::CPU_ADDR_W-1:0] addr,
	input cart_pkg::bank_state_t           banks
);
	expected_t                       e;
	logic [cart_pkg::BANK_W-1:0]     bank;
	logic [cart_pkg::ROM_ADDR_W-1:0] base;
	logic                            in_sc;
	e    = '0;
	base = '0;
	if (scheme_sel == cart_pkg::SCHEME_E0) begin
		case (addr[11:10])
			2'd0:    bank = banks.slice0;
			2'd1:    bank = banks.slice1;
			2'd2:    bank = banks.slice2;
			default: bank = cart_pkg::E0_FIXED_BANK;
		endcase
		base[cart_pkg::BANK_W-1:0] = bank;
		e.rom_a = base << 10;
		e.rom_a[9:0] = addr[9:0];
	end else begin
		bank = (scheme_sel == cart_pkg::SCHEME_4K) ? 3'd0 : banks.main_bank;
		base[cart_pkg::BANK_W-1:0] = bank;
		e.rom_a = base << 12;
		e.rom_a[11:0] = addr[11:0];
	end
	// Write port then read port, 128 bytes each
	in_sc = sc_en && (addr >= cart_pkg::SC_WRITE_BASE)
		&& (addr < cart_pkg::SC_READ_BASE + 13'd128);
	e.ram.sel  = in_sc;
	e.ram.rw   = in_sc ? addr[7] : 1'b1;
	e.ram.addr = '0;
	if (in_sc) begin
		e.ram.addr[6:0] = addr[6:0];
	end
	e.oe = addr[12] && !(in_sc && !addr[7]);
	return e;
endfunction

task automatic check_rom_a(
	input logic [cart_pkg::ROM_ADDR_W-1:0] actual,
	input logic [cart_pkg::ROM_ADDR_W-1:0] expected
);
	if (actual !== expected) begin
		fail_run($sformatf("ERR rom_a: got 0x%h, expected 0x%h at %0t",
			actual, expected, $time));
	end
endtask

task automatic check_ram(
	input cart_pkg::ram_port_t actual,
	input cart_pkg::ram_port_t expected
);
	if (actual !== expected) begin
		fail_run($sformatf("ERR ram: got 0x%h (sel %h rw %h addr 0x%h), expected 0x%h at %0t",
			actual, actual.sel, actual.rw, actual.addr, expected, $time));
	end
endtask

task automatic check_oe(input logic actual, input logic expected);
	if (actual !== expected) begin
		fail_run($sformatf("ERR data_oe: got 0x%h, expected 0x%h at %0t",
			actual, expected, $time));
	end
endtask

`endif

// File: testbench/tb_cart_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the cartridge mapper. Drives reads and hotspot accesses
// in every scheme, keeps a bank model and compares all outputs each cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_cart_mapper;

	localparam int          CLK_PERIOD_NS   = 20;
	localparam int          DRIVE_DELAY_NS  = 2;
	localparam int          SAMPLE_DELAY_NS = CLK_PERIOD_NS - 1;
	localparam logic [31:0] RANDOM_SEED     = 32'h2abe189f;

	// Cycle budget of each phase
	localparam int INIT_CYCLES    = 4;
	localparam int RESTART_CYCLES = 5;
	localparam int SWEEP_STEPS    = 32;
	localparam int RAND_ACCESSES  = 150;
	localparam int E0_ROUNDS      = 4;
	localparam int SC_STEPS       = 64;
	localparam int PHASE1_CYCLES  = 5 * (RESTART_CYCLES + SWEEP_STEPS);
	localparam int PHASE2_CYCLES  = 3 * (RESTART_CYCLES + 2 * RAND_ACCESSES);
	localparam int PHASE3_CYCLES  = RESTART_CYCLES + E0_ROUNDS * 10 + 2 * RAND_ACCESSES;
	localparam int PHASE4_CYCLES  = 2 * (RESTART_CYCLES + SC_STEPS);
	localparam int PHASE5_CYCLES  = 3 * RESTART_CYCLES + 8 + 24 + 3 + 64;
	localparam int TOTAL_CYCLES   = INIT_CYCLES + PHASE1_CYCLES + PHASE2_CYCLES
		+ PHASE3_CYCLES + PHASE4_CYCLES + PHASE5_CYCLES;
	localparam int WATCHDOG_NS    = (TOTAL_CYCLES + 100) * CLK_PERIOD_NS;

	logic                            clk;
	logic                            reset;
	logic                            reset_req;
	cart_pkg::mapper_scheme_e        scheme;
	logic                            sc;
	logic [cart_pkg::CPU_ADDR_W-1:0] a_in;
	logic                            a_change;
	logic [cart_pkg::ROM_ADDR_W-1:0] rom_a;
	cart_pkg::ram_port_t             ram;
	logic                            data_oe;
	cart_pkg::bank_state_t           model_banks;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	`include "tb_cart_checks.svh"

	expected_t predicted;

	tb_clock_gen i_clock_gen (
		.reset_req (reset_req),
		.clk       (clk),
		.reset     (reset)
	);

	cart_mapper i_dut (
		.clk      (clk),
		.reset    (reset),
		.scheme   (scheme),
		.sc       (sc),
		.a_in     (a_in),
		.a_change (a_change),
		.rom_a    (rom_a),
		.ram      (ram),
		.data_oe  (data_oe)
	);

	function automatic cart_pkg::bank_state_t reset_banks(input cart_pkg::mapper_scheme_e s);
		cart_pkg::bank_state_t b;
		b = '0;
		b.main_bank = (s == cart_pkg::SCHEME_F8) ? cart_pkg::F8_RESET_BANK : 3'd0;
		return b;
	endfunction

	// Bank state after an access marked by a_change
	function automatic cart_pkg::bank_state_t apply_access(
		input cart_pkg::bank_state_t           banks,
		input cart_pkg::mapper_scheme_e        s,
		input logic [cart_pkg::CPU_ADDR_W-1:0] a
	);
		cart_pkg::bank_state_t next;
		int                    first;
		int                    count;
		int                    offs;
		next  = banks;
		first = 0;
		count = 0;
		case (s)
			cart_pkg::SCHEME_F8: begin
				first = int'(cart_pkg::HOT_F8_FIRST);
				count = int'(cart_pkg::F8_BANKS);
			end
			cart_pkg::SCHEME_F6: begin
				first = int'(cart_pkg::HOT_F6_FIRST);
				count = int'(cart_pkg::F6_BANKS);
			end
			cart_pkg::SCHEME_F4: begin
				first = int'(cart_pkg::HOT_F4_FIRST);
				count = int'(cart_pkg::F4_BANKS);
			end
			default: begin
				count = 0;
			end
		endcase
		offs = int'(a) - first;
		if (count > 0 && offs >= 0 && offs < count) begin
			next.main_bank = offs[cart_pkg::BANK_W-1:0];
		end
		if (s == cart_pkg::SCHEME_E0 && a >= cart_pkg::E0_HOT_FIRST
			&& a <= cart_pkg::E0_HOT_LAST) begin
			case (a[4:3])
				2'd0:    next.slice0 = a[2:0];
				2'd1:    next.slice1 = a[2:0];
				default: next.slice2 = a[2:0];
			endcase
		end
		return next;
	endfunction

	function automatic logic [cart_pkg::CPU_ADDR_W-1:0] pick_address();
		int unsigned                     kind;
		logic [cart_pkg::CPU_ADDR_W-1:0] addr;
		kind = $urandom % 4;
		case (kind)
			0, 1:    addr = cart_pkg::E0_HOT_FIRST + 13'($urandom % 32);
			2:       addr = 13'($urandom);
			default: addr = cart_pkg::SC_WRITE_BASE + 13'($urandom % 256);
		endcase
		return addr;
	endfunction

	task automatic drive_cycle(input logic [cart_pkg::CPU_ADDR_W-1:0] addr, input logic change);
		a_in     = addr;
		a_change = change;
		@(posedge clk);
		#(DRIVE_DELAY_NS);
	endtask

	task automatic wait_reset_release();
		do begin
			@(posedge clk);
		end while (reset);
		#(DRIVE_DELAY_NS);
	endtask

	task automatic restart(input cart_pkg::mapper_scheme_e new_scheme, input logic sc_level);
		a_change  = 1'b0;
		reset_req = 1'b1;
		@(posedge clk);
		#(DRIVE_DELAY_NS);
		reset_req = 1'b0;
		@(posedge clk);
		#(DRIVE_DELAY_NS);
		// Reset is already high here and the static inputs may move
		scheme = new_scheme;
		sc     = sc_level;
		wait_reset_release();
	endtask

	task automatic random_accesses(input int count);
		logic [cart_pkg::CPU_ADDR_W-1:0] addr;
		for (int i = 0; i < count; i++) begin
			addr = pick_address();
			drive_cycle(addr, ($urandom % 4) != 0);
			drive_cycle(addr, 1'b0);
		end
	endtask

	// Bank model follows the same edges as the DUT
	always @(posedge clk) begin
		if (reset) begin
			model_banks <= reset_banks(scheme);
		end else if (a_change) begin
			model_banks <= apply_access(model_banks, scheme, a_in);
		end
	end

	// Compare just before each rising edge
	initial begin
		@(posedge clk);
		forever begin
			#(SAMPLE_DELAY_NS);
			predicted = expected_outputs(scheme, sc, a_in, model_banks);
			check_rom_a(rom_a, predicted.rom_a);
			check_ram(ram, predicted.ram);
			check_oe(data_oe, predicted.oe);
			@(posedge clk);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("Watchdog expired: the stimulus did not finish in the expected time");
	end

	initial begin
		logic [cart_pkg::BANK_W-1:0]     bank;
		logic [cart_pkg::CPU_ADDR_W-1:0] addr;
		void'($urandom(RANDOM_SEED));
		reset_req = 1'b0;
		scheme    = cart_pkg::SCHEME_4K;
		sc        = 1'b0;
		a_in      = '0;
		a_change  = 1'b0;
		wait_reset_release();

		// Reset banks of every scheme swept with non-hotspot accesses
		for (int s = 0; s < 5; s++) begin
			restart(cart_pkg::mapper_scheme_e'(3'(s)), 1'b0);
			for (int k = 0; k < SWEEP_STEPS; k++) begin
				drive_cycle(13'(k * 255), 1'b1);
			end
		end

		// F8, F6 and F4 random switching
		for (int s = 1; s < 4; s++) begin
			restart(cart_pkg::mapper_scheme_e'(3'(s)), 1'b0);
			random_accesses(RAND_ACCESSES);
		end

		// E0 slices set one by one and read back through each 1K window
		restart(cart_pkg::SCHEME_E0, 1'b0);
		for (int r = 0; r < E0_ROUNDS; r++) begin
			for (int slot = 0; slot < 3; slot++) begin
				bank = 3'((r * 3 + slot + 1) % 8);
				addr = cart_pkg::E0_HOT_FIRST + 13'(slot * 8) + 13'(bank);
				drive_cycle(addr, 1'b1);
				drive_cycle(addr, 1'b0);
			end
			for (int q = 0; q < 4; q++) begin
				drive_cycle(13'h1000 + 13'(q * 1024) + 13'h0155, 1'b0);
			end
		end
		random_accesses(RAND_ACCESSES);

		// Superchip ports with the RAM enabled and disabled
		restart(cart_pkg::SCHEME_F6, 1'b1);
		for (int k = 0; k < SC_STEPS; k++) begin
			drive_cycle(cart_pkg::SC_WRITE_BASE + 13'(k * 4), 1'b1);
		end
		restart(cart_pkg::SCHEME_F6, 1'b0);
		for (int k = 0; k < SC_STEPS; k++) begin
			drive_cycle(cart_pkg::SC_WRITE_BASE + 13'(k * 4), 1'b1);
		end

		// Hotspots without a_change and plain 4K with it
		restart(cart_pkg::SCHEME_F4, 1'b0);
		for (int k = 0; k < 8; k++) begin
			drive_cycle(cart_pkg::HOT_F4_FIRST + 13'(k), 1'b0);
		end
		restart(cart_pkg::SCHEME_E0, 1'b0);
		for (int k = 0; k < 24; k++) begin
			drive_cycle(cart_pkg::E0_HOT_FIRST + 13'(k), 1'b0);
		end
		// E0 hotspots sit in the fixed slice so the switchable slices are read here
		for (int q = 0; q < 3; q++) begin
			drive_cycle(13'h1000 + 13'(q * 1024) + 13'h0155, 1'b0);
		end
		restart(cart_pkg::SCHEME_4K, 1'b0);
		for (int k = 0; k < 32; k++) begin
			drive_cycle(cart_pkg::E0_HOT_FIRST + 13'(k), 1'b1);
			drive_cycle(cart_pkg::E0_HOT_FIRST + 13'(k), 1'b0);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: cart_mapper.f
+incdir+testbench
design/cart_pkg.sv
design/hotspot_decoder.sv
design/bank_registers.sv
design/address_composer.sv
design/cart_mapper.sv
testbench/tb_clock_gen.sv
testbench/tb_cart_mapper.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the mapper testbench with Verilator, run it and scan the log.

set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"
rm -f "$LOG_FILE"

verilator --binary --timing -j 0 \
	--top-module tb_cart_mapper \
	-Mdir "$BUILD_DIR" \
	-f cart_mapper.f

"./$BUILD_DIR/Vtb_cart_mapper" 2>&1 | tee "$LOG_FILE"

if grep -qx "TEST PASSED" "$LOG_FILE"; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail"
	exit 1
fi
